// File: lsu_top.f
verilog/lsu_pkg.sv
verilog/mem_pkg.sv
verilog/lsu_skid_buffer.sv
verilog/agu.sv
verilog/load_queue.sv
verilog/store_queue.sv
verilog/lsu_top.sv
dv/lsu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= lsu_tb
RTL_TOP   ?= lsu_top
FILELIST  ?= lsu_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "*** TEST PASSED ***" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) \
		verilog/lsu_pkg.sv verilog/mem_pkg.sv verilog/lsu_skid_buffer.sv \
		verilog/agu.sv verilog/load_queue.sv verilog/store_queue.sv verilog/lsu_top.sv

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/lsu_tb.sv
module lsu_tb;
    import lsu_pkg::*;
    import mem_pkg::*;

    localparam int NUM_OPS     = 400;
    localparam int FLUSH_EVERY = 97;
    localparam int CYCLE_LIMIT = NUM_OPS * 40 + 1000;

    logic     cpu_clock_i;
    logic     rst_i;
    logic     flush_i;
    logic     lsu_vld_i;
    lsu_req_t lsu_req_i;
    logic     lsu_busy_o;
    logic     ld_vld_o;
    ld_req_t  ld_req_o;
    logic     ld_rdy_i;
    logic     st_vld_o;
    st_req_t  st_req_o;
    logic     st_rdy_i;
    logic     excp_vld_o;
    excp_t    excp_o;

    ld_req_t exp_ld[$];
    st_req_t exp_st[$];
    excp_t   exp_ex[$];
    int      cycle = 0;
    int      mism = 0;
    int      extra = 0;
    int      ld_due = -1;
    int      st_due = -1;
    int      st_quiet = -1;
    int      ex_due = -1;
    bit      rst_seen = 1'b1;
    bit      flush_seen = 1'b0;
    bit      ld_hold = 1'b0;
    bit      st_hold = 1'b0;
    ld_req_t ld_prev;
    st_req_t st_prev;

    lsu_top u_dut (.*);

    initial begin
        cpu_clock_i = 1'b0;
        forever #2 cpu_clock_i = ~cpu_clock_i;
    end

    // ------------------------------
    // Reference model
    // ------------------------------
    task automatic expect_op(input lsu_req_t r, input bit idle);
        int         off;
        int         sz;
        bit         bad;
        logic [3:0] mask;
        logic [31:0] lane;
        ld_req_t    l;
        st_req_t    s;
        excp_t      e;
        off  = int'(r.addr[1:0]);
        sz   = int'(r.op[1:0]);
        bad  = !(r.op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW})
               || sz == 3 || (off % (1 << sz)) != 0;
        mask = (sz == 0) ? (4'b0001 << off) : (sz == 1) ? (4'b0011 << off) : 4'b1111;
        lane = (sz == 0) ? {24'd0, r.data[7:0]} : (sz == 1) ? {16'd0, r.data[15:0]} : r.data;
        lane = lane << (8 * off);
        if (bad) begin
            e.pc   = r.addr;
            e.code = r.op[3] ? EXC_ST_MISALIGN : EXC_LD_MISALIGN;
            e.rob  = r.rob;
            exp_ex.push_back(e);
            if (idle) ex_due = cycle + 1;
        end else if (r.op[3]) begin
            s.waddr = r.addr[31:2];
            s.data  = lane;
            s.bm    = mask;
            s.io    = r.addr[31];
            s.rob   = r.rob;
            exp_st.push_back(s);
            if (idle) begin
                st_due   = cycle + 2;
                st_quiet = -1;
                if (r.addr[31]) begin
                    st_due   = cycle + 3;  // Device store sits one cycle at the head
                    st_quiet = cycle + 2;
                end
            end
        end else begin
            l.addr    = r.addr;
            l.ld_type = r.op[2:0];
            l.dest    = r.dest;
            l.rob     = r.rob;
            exp_ld.push_back(l);
            if (idle) ld_due = cycle + 2;
        end
    endtask

    function automatic lsu_req_t random_op();
        lsu_req_t r;
        int       pick;
        pick   = $urandom_range(9);
        r.rob  = ROB_W'($urandom);
        r.dest = DEST_W'($urandom);
        r.data = $urandom;
        r.addr = $urandom;
        case (pick)
            0: r.op = OP_LB;
            1: r.op = OP_LH;
            2: r.op = OP_LW;
            3: r.op = OP_LBU;
            4: r.op = OP_LHU;
            5: r.op = OP_SB;
            6: r.op = OP_SH;
            7: r.op = OP_SW;
            default: begin
                // Any unused encoding, legal sizes included
                r.op = lsu_op_e'(4'($urandom_range(15)));
                while (r.op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
                                    OP_SB, OP_SH, OP_SW}) begin
                    r.op = lsu_op_e'(4'($urandom_range(15)));
                end
            end
        endcase
        if ($urandom_range(3) != 0) r.addr[31] = 1'b0;
        if ($urandom_range(2) != 0) r.addr[1:0] = 2'b00;  // Keep most ops aligned
        return r;
    endfunction

    task automatic clear_expected();
        exp_ld.delete();
        exp_st.delete();
        exp_ex.delete();
        ld_due   = -1;
        st_due   = -1;
        st_quiet = -1;
        ex_due   = -1;
    endtask

    // ------------------------------
    // Port checks
    // ------------------------------
    always @(posedge cpu_clock_i) begin
        if (rst_i) begin
            clear_expected();
            rst_seen = 1'b1;
            ld_hold  = 1'b0;
            st_hold  = 1'b0;
        end else begin
            if (rst_seen || flush_seen) begin
                assert (!ld_vld_o && !st_vld_o && !excp_vld_o && !lsu_busy_o) else begin
                    $display("ERR @%0t: valid or busy high after reset or flush", $time);
                    mism++;
                end
            end else begin
                assert (!ld_hold || (ld_vld_o && ld_req_o == ld_prev)) else begin
                    $display("ERR @%0t: load payload changed while stalled", $time);
                    mism++;
                end
                assert (!st_hold || (st_vld_o && st_req_o == st_prev)) else begin
                    $display("ERR @%0t: store payload changed while stalled", $time);
                    mism++;
                end
            end
            assert (cycle != ld_due || ld_vld_o) else begin
                $display("ERR @%0t: idle load not at port 2 cycles after accept", $time);
                mism++;
            end
            assert (cycle != st_due || st_vld_o) else begin
                $display("ERR @%0t: idle store not at port when due", $time);
                mism++;
            end
            assert (cycle != st_quiet || !st_vld_o) else begin
                $display("ERR @%0t: idle device store issued without its extra wait", $time);
                mism++;
            end
            assert (cycle != ex_due || excp_vld_o) else begin
                $display("ERR @%0t: exception not 1 cycle after accept", $time);
                mism++;
            end
            if (ld_vld_o && ld_rdy_i) begin
                if (exp_ld.size() == 0) begin
                    $display("Unexpected load request at %0t with no load pending", $time);
                    extra++;
                end else begin
                    assert (ld_req_o == exp_ld[0]) else begin
                        $display("ERR @%0t: load got %h exp %h", $time, ld_req_o, exp_ld[0]);
                        mism++;
                    end
                    void'(exp_ld.pop_front());
                end
            end
            if (st_vld_o && st_rdy_i) begin
                if (exp_st.size() == 0) begin
                    $display("Unexpected store request at %0t with no store pending", $time);
                    extra++;
                end else begin
                    assert (st_req_o == exp_st[0]) else begin
                        $display("ERR @%0t: store got %h exp %h", $time, st_req_o, exp_st[0]);
                        mism++;
                    end
                    void'(exp_st.pop_front());
                end
            end
            if (excp_vld_o) begin
                if (exp_ex.size() == 0) begin
                    $display("Unexpected exception at %0t with no faulting op pending", $time);
                    extra++;
                end else begin
                    assert (excp_o == exp_ex[0]) else begin
                        $display("ERR @%0t: excp got %h exp %h", $time, excp_o, exp_ex[0]);
                        mism++;
                    end
                    void'(exp_ex.pop_front());
                end
            end
            if (flush_i) begin
                clear_expected();  // Everything in flight is dropped
            end else if (lsu_vld_i && !lsu_busy_o) begin
                expect_op(lsu_req_i, exp_ld.size() == 0 && exp_st.size() == 0
                          && exp_ex.size() == 0);
            end
            rst_seen   = 1'b0;
            flush_seen = flush_i;
            ld_hold    = ld_vld_o && !ld_rdy_i;
            st_hold    = st_vld_o && !st_rdy_i;
            ld_prev    = ld_req_o;
            st_prev    = st_req_o;
        end
        cycle++;
    end

    always @(posedge cpu_clock_i) begin
        if (cycle > CYCLE_LIMIT) begin
            $display("Timeout: run exceeded %0d cycles with ops still pending", CYCLE_LIMIT);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // Memory ready with long back-pressure phases
    initial begin
        int  len;
        bit  slow;
        @(posedge cpu_clock_i);
        forever begin
            len  = $urandom_range(40, 5);
            slow = ($urandom_range(3) == 0);
            repeat (len) begin
                @(posedge cpu_clock_i);
                ld_rdy_i <= slow ? ($urandom_range(7) == 0) : ($urandom_range(3) != 0);
                st_rdy_i <= slow ? ($urandom_range(7) == 0) : ($urandom_range(3) != 0);
            end
        end
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial begin
        void'($urandom(32'hcfe2_481f));
        rst_i     = 1'b1;
        flush_i   = 1'b0;
        lsu_vld_i = 1'b0;
        lsu_req_i = '0;
        ld_rdy_i  = 1'b1;
        st_rdy_i  = 1'b1;
        repeat (16) @(posedge cpu_clock_i);
        rst_i <= 1'b0;
        for (int i = 0; i < NUM_OPS; i++) begin
            if (i % FLUSH_EVERY == FLUSH_EVERY - 1) begin
                lsu_vld_i <= 1'b0;
                @(posedge cpu_clock_i);
                flush_i <= 1'b1;
                @(posedge cpu_clock_i);
                flush_i <= 1'b0;
            end
            if ($urandom_range(3) == 0) begin
                lsu_vld_i <= 1'b0;
                repeat ($urandom_range(8, 1)) @(posedge cpu_clock_i);
            end
            lsu_req_i <= random_op();
            lsu_vld_i <= 1'b1;
            @(posedge cpu_clock_i);
            while (lsu_busy_o) @(posedge cpu_clock_i);  // Hold until accepted
        end
        lsu_vld_i <= 1'b0;
        while (exp_ld.size() != 0 || exp_st.size() != 0 || exp_ex.size() != 0) begin
            @(posedge cpu_clock_i);
        end
        repeat (10) @(posedge cpu_clock_i);
        $display("Errors: mismatches=%0d unexpected=%0d", mism, extra);
        if (mism == 0 && extra == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: verilog/lsu_top.sv
module lsu_top (
    input  logic              cpu_clock_i,
    input  logic              rst_i,
    input  logic              flush_i,

    // Issue side
    input  logic              lsu_vld_i,
    input  lsu_pkg::lsu_req_t lsu_req_i,
    output logic              lsu_busy_o,

    // Memory read port
    output logic              ld_vld_o,
    output mem_pkg::ld_req_t  ld_req_o,
    input  logic              ld_rdy_i,

    // Memory write port
    output logic              st_vld_o,
    output mem_pkg::st_req_t  st_req_o,
    input  logic              st_rdy_i,

    output logic              excp_vld_o,
    output mem_pkg::excp_t    excp_o
);
    import lsu_pkg::*;
    import mem_pkg::*;

    lsu_req_t skid_req;
    logic     skid_vld;
    logic     agu_stall;

    ld_req_t  lq_wr;
    logic     lq_wr_vld;
    logic     lq_full;

    st_req_t  sq_wr;
    logic     sq_wr_vld;
    logic     sq_full;

    lsu_skid_buffer u_skid (
        .cpu_clock_i (cpu_clock_i),
        .rst_i       (rst_i),
        .flush_i     (flush_i),
        .in_vld_i    (lsu_vld_i),
        .in_req_i    (lsu_req_i),
        .busy_o      (lsu_busy_o),
        .stall_i     (agu_stall),
        .out_vld_o   (skid_vld),
        .out_req_o   (skid_req)
    );

    agu u_agu (
        .cpu_clock_i (cpu_clock_i),
        .rst_i       (rst_i),
        .flush_i     (flush_i),
        .op_vld_i    (skid_vld),
        .op_req_i    (skid_req),
        .stall_o     (agu_stall),
        .lq_full_i   (lq_full),
        .lq_wr_vld_o (lq_wr_vld),
        .lq_wr_o     (lq_wr),
        .sq_full_i   (sq_full),
        .sq_wr_vld_o (sq_wr_vld),
        .sq_wr_o     (sq_wr),
        .excp_vld_o  (excp_vld_o),
        .excp_o      (excp_o)
    );

    load_queue #(.DEPTH(LQ_DEPTH)) u_lq (
        .cpu_clock_i (cpu_clock_i),
        .rst_i       (rst_i),
        .flush_i     (flush_i),
        .wr_vld_i    (lq_wr_vld),
        .wr_i        (lq_wr),
        .full_o      (lq_full),
        .ld_vld_o    (ld_vld_o),
        .ld_req_o    (ld_req_o),
        .ld_rdy_i    (ld_rdy_i)
    );

    store_queue #(.DEPTH(SQ_DEPTH)) u_sq (
        .cpu_clock_i (cpu_clock_i),
        .rst_i       (rst_i),
        .flush_i     (flush_i),
        .wr_vld_i    (sq_wr_vld),
        .wr_i        (sq_wr),
        .full_o      (sq_full),
        .st_vld_o    (st_vld_o),
        .st_req_o    (st_req_o),
        .st_rdy_i    (st_rdy_i)
    );

endmodule

// File: verilog/store_queue.sv
module store_queue #(
    parameter int DEPTH = mem_pkg::SQ_DEPTH
) (
    input  logic             cpu_clock_i,
    input  logic             rst_i,
    input  logic             flush_i,

    input  logic             wr_vld_i,
    input  mem_pkg::st_req_t wr_i,
    output logic             full_o,

    output logic             st_vld_o,
    output mem_pkg::st_req_t st_req_o,
    input  logic             st_rdy_i
);
    import mem_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    st_req_t          mem_q [DEPTH];
    st_req_t          head;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             not_empty;
    logic             head_aged_q;  // Head has sat for a cycle
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + PTR_W'(1);
    endfunction

    assign head      = mem_q[rd_ptr_q];
    assign not_empty = (count_q != '0);
    assign full_o    = (count_q == CNT_W'(DEPTH));

    // Device stores wait one cycle at the head
    assign st_vld_o = not_empty & (~head.io | head_aged_q);
    assign st_req_o = head;

    assign push = wr_vld_i & ~full_o;
    assign pop  = st_vld_o & st_rdy_i;

    // ------------------------------
    // Pointers and count
    // ------------------------------
    always_ff @(posedge cpu_clock_i) begin
        if (rst_i || flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            if (push && !pop) begin
                count_q <= count_q + CNT_W'(1);
            end else if (pop && !push) begin
                count_q <= count_q - CNT_W'(1);
            end
        end
    end

    // New head after a pop or on an empty queue restarts the wait
    always_ff @(posedge cpu_clock_i) begin
        if (rst_i || flush_i) begin
            head_aged_q <= 1'b0;
        end else if (pop || !not_empty) begin
            head_aged_q <= 1'b0;
        end else begin
            head_aged_q <= 1'b1;
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= wr_i;
        end
    end

endmodule

// File: verilog/load_queue.sv
module load_queue #(
    parameter int DEPTH = mem_pkg::LQ_DEPTH
) (
    input  logic             cpu_clock_i,
    input  logic             rst_i,
    input  logic             flush_i,

    input  logic             wr_vld_i,
    input  mem_pkg::ld_req_t wr_i,
    output logic             full_o,

    output logic             ld_vld_o,
    output mem_pkg::ld_req_t ld_req_o,
    input  logic             ld_rdy_i
);
    import mem_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    ld_req_t          mem_q [DEPTH];
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + PTR_W'(1);
    endfunction

    assign full_o   = (count_q == CNT_W'(DEPTH));
    assign ld_vld_o = (count_q != '0);
    assign ld_req_o = mem_q[rd_ptr_q];  // Head stays put until popped
    assign push     = wr_vld_i & ~full_o;
    assign pop      = ld_vld_o & ld_rdy_i;

    always_ff @(posedge cpu_clock_i) begin
        if (rst_i || flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            if (push && !pop) begin
                count_q <= count_q + CNT_W'(1);
            end else if (pop && !push) begin
                count_q <= count_q - CNT_W'(1);
            end
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= wr_i;
        end
    end

endmodule

// File: verilog/agu.sv
module agu (
    input  logic              cpu_clock_i,
    input  logic              rst_i,
    input  logic              flush_i,

    input  logic              op_vld_i,
    input  lsu_pkg::lsu_req_t op_req_i,
    output logic              stall_o,

    // Load path
    input  logic              lq_full_i,
    output logic              lq_wr_vld_o,
    output mem_pkg::ld_req_t  lq_wr_o,

    // Store path
    input  logic              sq_full_i,
    output logic              sq_wr_vld_o,
    output mem_pkg::st_req_t  sq_wr_o,

    output logic              excp_vld_o,
    output mem_pkg::excp_t    excp_o
);
    import lsu_pkg::*;
    import mem_pkg::*;

    logic [1:0]      offset;
    logic [1:0]      size;
    logic            is_store;
    logic            op_legal;
    logic            misaligned;
    logic            take;
    logic [3:0]      bm;
    logic [XLEN-1:0] st_data;

    assign offset   = op_req_i.addr[1:0];
    assign size     = op_req_i.op[1:0];
    assign is_store = op_req_i.op[3];
    assign stall_o  = lq_full_i | sq_full_i;  // Either queue full holds the AGU
    assign take     = op_vld_i & ~stall_o;

    always_comb begin
        case (op_req_i.op)
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
            OP_SB, OP_SH, OP_SW: op_legal = 1'b1;
            default:             op_legal = 1'b0;
        endcase
    end

    // ------------------------------
    // Size and offset decode
    // ------------------------------
    always_comb begin
        bm         = 4'b0000;
        st_data    = '0;
        misaligned = 1'b0;
        case ({offset, size})
            4'b0000: begin
                bm      = 4'b0001;
                st_data = {24'd0, op_req_i.data[7:0]};
            end
            4'b0100: begin
                bm      = 4'b0010;
                st_data = {16'd0, op_req_i.data[7:0], 8'd0};
            end
            4'b1000: begin
                bm      = 4'b0100;
                st_data = {8'd0, op_req_i.data[7:0], 16'd0};
            end
            4'b1100: begin
                bm      = 4'b1000;
                st_data = {op_req_i.data[7:0], 24'd0};
            end
            4'b0001: begin
                bm      = 4'b0011;
                st_data = {16'd0, op_req_i.data[15:0]};
            end
            4'b1001: begin
                bm      = 4'b1100;
                st_data = {op_req_i.data[15:0], 16'd0};
            end
            4'b0010: begin
                bm      = 4'b1111;
                st_data = op_req_i.data;
            end
            default: misaligned = 1'b1;
        endcase
        if (!op_legal) begin
            misaligned = 1'b1;  // Unknown encodings fault too
        end
    end

    // ------------------------------
    // Output valids
    // ------------------------------
    always_ff @(posedge cpu_clock_i) begin
        if (rst_i || flush_i) begin
            lq_wr_vld_o <= 1'b0;
            sq_wr_vld_o <= 1'b0;
            excp_vld_o  <= 1'b0;
        end else begin
            // A queue that is not full consumed its write this cycle
            if (!lq_full_i) begin
                lq_wr_vld_o <= take & ~is_store & ~misaligned;
            end
            if (!sq_full_i) begin
                sq_wr_vld_o <= take & is_store & ~misaligned;
            end
            excp_vld_o <= take & misaligned;  // Single pulse
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (take && !is_store) begin
            lq_wr_o.addr    <= op_req_i.addr;
            lq_wr_o.ld_type <= op_req_i.op[2:0];
            lq_wr_o.dest    <= op_req_i.dest;
            lq_wr_o.rob     <= op_req_i.rob;
        end
        if (take && is_store) begin
            sq_wr_o.waddr <= op_req_i.addr[31:2];
            sq_wr_o.data  <= st_data;
            sq_wr_o.bm    <= bm;
            sq_wr_o.io    <= op_req_i.addr[31];
            sq_wr_o.rob   <= op_req_i.rob;
        end
        if (take && misaligned) begin
            excp_o.pc   <= op_req_i.addr;
            excp_o.code <= is_store ? EXC_ST_MISALIGN : EXC_LD_MISALIGN;
            excp_o.rob  <= op_req_i.rob;
        end
    end

endmodule

// File: verilog/lsu_skid_buffer.sv
module lsu_skid_buffer (
    input  logic              cpu_clock_i,
    input  logic              rst_i,
    input  logic              flush_i,

    input  logic              in_vld_i,
    input  lsu_pkg::lsu_req_t in_req_i,
    output logic              busy_o,

    input  logic              stall_i,
    output logic              out_vld_o,
    output lsu_pkg::lsu_req_t out_req_o
);
    import lsu_pkg::*;

    lsu_req_t spare_q;
    logic     spare_vld_q;
    logic     capture;

    // Op accepted this cycle but the AGU cannot take it
    assign capture = ~spare_vld_q & in_vld_i & stall_i;

    assign busy_o    = spare_vld_q;
    assign out_vld_o = spare_vld_q | in_vld_i;
    assign out_req_o = spare_vld_q ? spare_q : in_req_i;  // Spare replays first

    // ------------------------------
    // Spare entry control
    // ------------------------------
    always_ff @(posedge cpu_clock_i) begin
        if (rst_i || flush_i) begin
            spare_vld_q <= 1'b0;
        end else if (spare_vld_q) begin
            if (!stall_i) begin
                spare_vld_q <= 1'b0;  // Drained into the AGU
            end
        end else if (capture) begin
            spare_vld_q <= 1'b1;
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (capture) begin
            spare_q <= in_req_i;
        end
    end

endmodule

// File: verilog/mem_pkg.sv
package mem_pkg;

    localparam int LQ_DEPTH = 4;
    localparam int SQ_DEPTH = 4;

    // Read port request, 47 bits
    typedef struct packed {
        logic [31:0]                addr;
        logic [2:0]                 ld_type;  // Low opcode bits
        logic [lsu_pkg::DEST_W-1:0] dest;
        logic [lsu_pkg::ROB_W-1:0]  rob;
    } ld_req_t;

    // Write port request, 73 bits
    typedef struct packed {
        logic [29:0]               waddr;  // Word address
        logic [31:0]               data;   // Already lane aligned
        logic [3:0]                bm;
        logic                      io;     // Address bit 31
        logic [lsu_pkg::ROB_W-1:0] rob;
    } st_req_t;

    typedef enum logic [3:0] {
        EXC_LD_MISALIGN = 4'd4,
        EXC_ST_MISALIGN = 4'd6
    } excp_code_e;

    typedef struct packed {
        logic [31:0]               pc;     // Faulting address
        excp_code_e                code;
        logic [lsu_pkg::ROB_W-1:0] rob;
    } excp_t;

endpackage

// File: verilog/lsu_pkg.sv
package lsu_pkg;

    localparam int ROB_W  = 6;
    localparam int DEST_W = 6;
    localparam int XLEN   = 32;

    // ------------------------------
    // Micro-op encoding
    // Bit 3 store, bit 2 unsigned load, bits 1:0 size
    // ------------------------------
    typedef enum logic [3:0] {
        OP_LB  = 4'b0000,
        OP_LH  = 4'b0001,
        OP_LW  = 4'b0010,
        OP_LBU = 4'b0100,
        OP_LHU = 4'b0101,
        OP_SB  = 4'b1000,
        OP_SH  = 4'b1001,
        OP_SW  = 4'b1010
    } lsu_op_e;

    // Issue request, 80 bits
    typedef struct packed {
        logic [ROB_W-1:0]  rob;
        lsu_op_e           op;
        logic [XLEN-1:0]   data;   // Store data, unshifted
        logic [XLEN-1:0]   addr;   // Effective address
        logic [DEST_W-1:0] dest;
    } lsu_req_t;

endpackage
